/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/lsu_split_fsm.sv
      - source/lsu_txn_tracker.sv
      - source/lsu_rdata_align.sv
      - source/lsu_top.sv
  - target: test
    files:
      - tb/tb_lsu_top.sv

/* lsu.f */
+incdir+source
source/lsu_pkg.sv
source/lsu_split_fsm.sv
source/lsu_txn_tracker.sv
source/lsu_rdata_align.sv
source/lsu_top.sv
tb/tb_lsu_top.sv

/* source/lsu_macros.svh */
/*
  Load/store unit widths and depths
  Shared sizing for the package and the RTL blocks
*/

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Core and bus address width
`define LSU_ADDR_W 32

// Data word width
`define LSU_DATA_W 32

// One enable per byte lane
`define LSU_BE_W 4

// Byte offset inside a data word
`define LSU_OFFSET_W 2

// Bus transactions allowed in flight
`define LSU_MAX_OUTSTANDING 2

// Wide enough to hold LSU_MAX_OUTSTANDING
`define LSU_CNT_W 2

`endif

/* source/lsu_pkg.sv */
/*
  Load/store unit types
  Vector widths, access size and sequencer state, request and response records
*/

`include "lsu_macros.svh"

package lsu_pkg;

  // Vectors with a meaning
  typedef logic [`LSU_ADDR_W-1:0]   addr_t;
  typedef logic [`LSU_DATA_W-1:0]   data_t;
  typedef logic [`LSU_BE_W-1:0]     be_t;
  typedef logic [`LSU_OFFSET_W-1:0] offset_t;
  typedef logic [`LSU_CNT_W-1:0]    cnt_t;

  // Access size encoding
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Sequencer state for split accesses
  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_SECOND
  } split_state_e;

  // One access from the core, final byte address
  typedef struct packed {
    addr_t     addr;
    logic      we;
    lsu_size_e size;
    logic      sign_ext;
    data_t     wdata;
  } lsu_req_t;

  // One word-aligned bus transaction
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  // Read data and error from the bus
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // What the read side needs per transaction
  typedef struct packed {
    lsu_size_e size;
    offset_t   offset;
    logic      sign_ext;
    logic      we;
    logic      last;
  } txn_info_t;

endpackage

/* source/lsu_rdata_align.sv */
/*
  Read data aligner
  Joins split loads, picks the byte/half/word lane and extends it
*/

`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rvalid_i,
  input  lsu_pkg::bus_rsp_t   rsp_i,
  input  lsu_pkg::txn_info_t  info_i,
  output logic                rsp_valid_o,
  output lsu_pkg::data_t      rsp_rdata_o,
  output logic                rsp_err_o
);

  lsu_pkg::data_t rdata_q;
  lsu_pkg::data_t new_word;
  lsu_pkg::data_t word_ext;
  logic [15:0]    half_sel;
  logic [7:0]     byte_sel;
  logic           err_q;

  assign new_word = rsp_i.rdata;

  ////////////////////////////////////////////////////////////
  // First part storage
  ////////////////////////////////////////////////////////////

  // Lower word of a split access waits here
  always_ff @(posedge clk)
  begin
    if (rvalid_i && !info_i.last && !info_i.we)
      rdata_q <= new_word;
  end

  // Error sticks until the last part of the same access
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      err_q <= 1'b0;
    else if (rvalid_i)
      err_q <= info_i.last ? 1'b0 : rsp_i.err;
  end

  ////////////////////////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////////////////////////

  // Word, nonzero offsets take low bytes from the stored word
  always_comb
  begin
    case (info_i.offset)
      2'b00:   word_ext = new_word;
      2'b01:   word_ext = {new_word[7:0], rdata_q[31:8]};
      2'b10:   word_ext = {new_word[15:0], rdata_q[31:16]};
      default: word_ext = {new_word[23:0], rdata_q[31:24]};
    endcase
  end

  // Halfword, top lane straddles the two words
  always_comb
  begin
    case (info_i.offset)
      2'b00:   half_sel = new_word[15:0];
      2'b01:   half_sel = new_word[23:8];
      2'b10:   half_sel = new_word[31:16];
      default: half_sel = {new_word[7:0], rdata_q[31:24]};
    endcase
  end

  // Byte never splits
  assign byte_sel = new_word[{info_i.offset, 3'b000} +: 8];

  ////////////////////////////////////////////////////////////
  // Extension and output
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (info_i.size)
      lsu_pkg::LSU_BYTE:
        rsp_rdata_o = {{24{info_i.sign_ext & byte_sel[7]}}, byte_sel};
      lsu_pkg::LSU_HALF:
        rsp_rdata_o = {{16{info_i.sign_ext & half_sel[15]}}, half_sel};
      default:
        rsp_rdata_o = word_ext;
    endcase
  end

  // One response per access, on its final part
  assign rsp_valid_o = rvalid_i && info_i.last;

  // Either half failing fails the access
  assign rsp_err_o = rsp_i.err || err_q;

endmodule

/* source/lsu_split_fsm.sv */
/*
  Access sequencer
  Splits boundary-crossing accesses into two word-aligned bus requests
  and builds byte enables and lane-rotated write data for each part
*/

`timescale 1ns/1ps

`include "lsu_macros.svh"

module lsu_split_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                core_req_valid_i,
  input  lsu_pkg::lsu_req_t   core_req_i,
  output logic                core_req_ready_o,
  input  logic                full_i,
  input  logic                bus_gnt_i,
  output logic                bus_req_o,
  output lsu_pkg::bus_req_t   bus_req_data_o,
  output lsu_pkg::txn_info_t  txn_info_o
);

  lsu_pkg::split_state_e state_q;
  lsu_pkg::split_state_e state_d;
  lsu_pkg::offset_t      offset;
  lsu_pkg::addr_t        word_addr;
  lsu_pkg::be_t          be_first;
  lsu_pkg::be_t          be_second;
  lsu_pkg::data_t        wdata_rot;
  logic                  crosses;
  logic                  in_second;
  logic                  last_part;
  logic                  granted;

  assign offset    = core_req_i.addr[1:0];
  assign word_addr = {core_req_i.addr[`LSU_ADDR_W-1:2], 2'b00};
  assign in_second = (state_q == lsu_pkg::SPLIT_SECOND);

  ////////////////////////////////////////////////////////////
  // Boundary detection
  ////////////////////////////////////////////////////////////

  // Word at any nonzero offset, or halfword in the top lane
  assign crosses = ((core_req_i.size == lsu_pkg::LSU_WORD) && (offset != 2'b00)) ||
                   ((core_req_i.size == lsu_pkg::LSU_HALF) && (offset == 2'b11));

  // Aligned accesses are their own last part
  assign last_part = !crosses || in_second;

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  // Lower word lanes from the offset upwards
  always_comb
  begin
    case (core_req_i.size)
      lsu_pkg::LSU_BYTE: be_first = 4'b0001 << offset;
      lsu_pkg::LSU_HALF:
      begin
        case (offset)
          2'b00:   be_first = 4'b0011;
          2'b01:   be_first = 4'b0110;
          2'b10:   be_first = 4'b1100;
          default: be_first = 4'b1000;
        endcase
      end
      default:
      begin
        case (offset)
          2'b00:   be_first = 4'b1111;
          2'b01:   be_first = 4'b1110;
          2'b10:   be_first = 4'b1100;
          default: be_first = 4'b1000;
        endcase
      end
    endcase
  end

  // Only the spill-over lanes of the upper word
  always_comb
  begin
    if (core_req_i.size == lsu_pkg::LSU_HALF)
      be_second = 4'b0001;
    else
    begin
      case (offset)
        2'b01:   be_second = 4'b0001;
        2'b10:   be_second = 4'b0011;
        2'b11:   be_second = 4'b0111;
        default: be_second = 4'b0000;
      endcase
    end
  end

  // Rotate left by the offset so byte 0 lands in its lane
  always_comb
  begin
    case (offset)
      2'b00:   wdata_rot = core_req_i.wdata;
      2'b01:   wdata_rot = {core_req_i.wdata[23:0], core_req_i.wdata[31:24]};
      2'b10:   wdata_rot = {core_req_i.wdata[15:0], core_req_i.wdata[31:16]};
      default: wdata_rot = {core_req_i.wdata[7:0], core_req_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////////////

  // Hold off while both slots are in flight
  assign bus_req_o = core_req_valid_i && !full_i;
  assign granted   = bus_req_o && bus_gnt_i;

  assign bus_req_data_o.addr  = in_second ? (word_addr + 32'd4) : word_addr;
  assign bus_req_data_o.we    = core_req_i.we;
  assign bus_req_data_o.be    = in_second ? be_second : be_first;
  assign bus_req_data_o.wdata = wdata_rot;

  assign txn_info_o.size     = core_req_i.size;
  assign txn_info_o.offset   = offset;
  assign txn_info_o.sign_ext = core_req_i.sign_ext;
  assign txn_info_o.we       = core_req_i.we;
  assign txn_info_o.last     = last_part;

  // Core moves on once its final part is accepted
  assign core_req_ready_o = granted && last_part;

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::SPLIT_IDLE:
      begin
        if (granted && crosses)
          state_d = lsu_pkg::SPLIT_SECOND;
      end
      default:
      begin
        if (granted)
          state_d = lsu_pkg::SPLIT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_pkg::SPLIT_IDLE;
    else
      state_q <= state_d;
  end

  // Pending request and its payload hold until granted
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) |=> (bus_req_o && $stable(bus_req_data_o)));

endmodule

/* source/lsu_top.sv */
/*
  Load/store unit
  Core access in, one or two word-aligned bus transactions out
*/

`timescale 1ns/1ps

module lsu_top (
  input  logic                clk,
  input  logic                rst_n,

  // Core request and response
  input  logic                core_req_valid_i,
  input  lsu_pkg::lsu_req_t   core_req_i,
  output logic                core_req_ready_o,
  output logic                core_rsp_valid_o,
  output lsu_pkg::data_t      core_rsp_rdata_o,
  output logic                core_rsp_err_o,

  // Data bus
  output logic                bus_req_o,
  output lsu_pkg::bus_req_t   bus_req_data_o,
  input  logic                bus_gnt_i,
  input  logic                bus_rvalid_i,
  input  lsu_pkg::bus_rsp_t   bus_rsp_i,

  output logic                busy_o
);

  logic               full;
  logic               push;
  lsu_pkg::txn_info_t txn_info;
  lsu_pkg::txn_info_t head_info;

  // Accepted transaction
  assign push = bus_req_o && bus_gnt_i;

  lsu_split_fsm u_split_fsm (
    .clk              (clk),
    .rst_n            (rst_n),
    .core_req_valid_i (core_req_valid_i),
    .core_req_i       (core_req_i),
    .core_req_ready_o (core_req_ready_o),
    .full_i           (full),
    .bus_gnt_i        (bus_gnt_i),
    .bus_req_o        (bus_req_o),
    .bus_req_data_o   (bus_req_data_o),
    .txn_info_o       (txn_info)
  );

  lsu_txn_tracker u_txn_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_info_i (txn_info),
    .pop_i       (bus_rvalid_i),
    .full_o      (full),
    .head_info_o (head_info),
    .busy_o      (busy_o),
    .bus_req_i   (bus_req_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .rvalid_i    (bus_rvalid_i),
    .rsp_i       (bus_rsp_i),
    .info_i      (head_info),
    .rsp_valid_o (core_rsp_valid_o),
    .rsp_rdata_o (core_rsp_rdata_o),
    .rsp_err_o   (core_rsp_err_o)
  );

endmodule

/* source/lsu_txn_tracker.sv */
/*
  Outstanding transaction tracker
  Counts bus transactions in flight and queues their alignment info
*/

`timescale 1ns/1ps

`include "lsu_macros.svh"

module lsu_txn_tracker (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_i,
  input  lsu_pkg::txn_info_t  push_info_i,
  input  logic                pop_i,
  output logic                full_o,
  output lsu_pkg::txn_info_t  head_info_o,
  output logic                busy_o,
  input  logic                bus_req_i
);

  localparam int unsigned PTR_W = $clog2(`LSU_MAX_OUTSTANDING);

  lsu_pkg::cnt_t      cnt_q;
  lsu_pkg::cnt_t      cnt_d;
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  lsu_pkg::txn_info_t queue_q [`LSU_MAX_OUTSTANDING];

  ////////////////////////////////////////////////////////////
  // Counter
  ////////////////////////////////////////////////////////////

  // Accept and response in one cycle cancel out
  always_comb
  begin
    case ({push_i, pop_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_d;
      if (push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Info queue
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push_i)
      queue_q[wr_ptr_q] <= push_info_i;
  end

  // Oldest in flight, matched to the next response
  assign head_info_o = queue_q[rd_ptr_q];

  assign full_o = (cnt_q == `LSU_MAX_OUTSTANDING);

  // Something in flight or about to be
  assign busy_o = (cnt_q != '0) || bus_req_i;

  // Sequencer must respect full
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !full_o);

  // Bus answers only what it granted
  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> (cnt_q != '0));

endmodule

/* tb/tb_lsu_top.sv */
/*
  Load/store unit testbench
  Random accesses checked against a byte-array model, with a bus memory
  that grants at random and answers in order after 1 to 3 cycles
*/

`timescale 1ns/1ps

module tb_lsu_top;

  localparam int         N_ACC          = 400;
  localparam int         TIMEOUT_CYCLES = N_ACC * 20;
  localparam logic [7:0] ERR_LO         = 8'hE0;
  localparam logic [7:0] ERR_HI         = 8'hEF;

  // Expected core response for one access
  typedef struct packed {
    logic [31:0] data;
    logic        err;
    logic        we;
  } exp_rsp_t;

  // Bus response waiting for its cycle
  typedef struct packed {
    lsu_pkg::bus_rsp_t rsp;
    int                due;
  } pend_t;

  logic               clk;
  logic               rst_n;
  logic               core_req_valid;
  lsu_pkg::lsu_req_t  core_req;
  logic               core_req_ready;
  logic               core_rsp_valid;
  lsu_pkg::data_t     core_rsp_rdata;
  logic               core_rsp_err;
  logic               bus_req;
  lsu_pkg::bus_req_t  bus_req_data;
  logic               bus_gnt;
  logic               bus_rvalid;
  lsu_pkg::bus_rsp_t  bus_rsp;
  logic               busy;

  logic [31:0]        lfsr;
  logic [7:0]         mem [256];
  logic [7:0]         model [256];
  lsu_pkg::bus_req_t  exp_bus [$];
  exp_rsp_t           exp_rsp [$];
  pend_t              pend [$];
  exp_rsp_t           got;
  lsu_pkg::lsu_req_t  next_req;
  logic [7:0]         last_addr;
  int                 cycles;
  int                 resp_cycle;
  int                 last_due;
  int                 outstanding;
  int                 rsp_count;
  int                 data_errs;
  int                 flag_errs;
  int                 bus_errs;
  int                 misc_errs;

  lsu_top uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .core_req_valid_i (core_req_valid),
    .core_req_i       (core_req),
    .core_req_ready_o (core_req_ready),
    .core_rsp_valid_o (core_rsp_valid),
    .core_rsp_rdata_o (core_rsp_rdata),
    .core_rsp_err_o   (core_rsp_err),
    .bus_req_o        (bus_req),
    .bus_req_data_o   (bus_req_data),
    .bus_gnt_i        (bus_gnt),
    .bus_rvalid_i     (bus_rvalid),
    .bus_rsp_i        (bus_rsp),
    .busy_o           (busy)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int j = 0; j < n; j++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic in_err_range(input logic [7:0] a);
    return (a >= ERR_LO) && (a <= ERR_HI);
  endfunction

  // Random access with its bus parts and its response built from the byte model
  task automatic make_access(output lsu_pkg::lsu_req_t req);
    logic [7:0]        a;
    logic [7:0]        b;
    logic [1:0]        sz;
    logic [31:0]       val;
    logic              err;
    int                n;
    int                s;
    lsu_pkg::bus_req_t part0;
    lsu_pkg::bus_req_t part1;
    // Some accesses revisit the last address so loads see fresh stores
    if (rand_bits(2) == 0)
      a = last_addr;
    else
      a = 8'(rand_bits(8));
    sz = 2'(rand_bits(2));
    case (sz)
      2'd0:    req.size = lsu_pkg::LSU_BYTE;
      2'd1:    req.size = lsu_pkg::LSU_HALF;
      default: req.size = lsu_pkg::LSU_WORD;
    endcase
    n            = (sz == 2'd0) ? 1 : ((sz == 2'd1) ? 2 : 4);
    req.addr     = {24'h0, a};
    req.we       = (rand_bits(2) == 3);
    req.sign_ext = rand_bits(1) != 0;
    req.wdata    = rand_bits(32);
    part0        = '0;
    part0.addr   = {24'h0, a[7:2], 2'b00};
    part0.we     = req.we;
    part1        = part0;
    part1.addr   = part0.addr + 32'd4;
    val          = '0;
    err          = 1'b0;
    for (int i = 0; i < n; i++)
    begin
      b = a + i[7:0];
      s = a[1:0] + i;
      // Lanes past the word end spill into the next word
      if (s < 4)
      begin
        part0.be[s]          = 1'b1;
        part0.wdata[8*s +: 8] = req.wdata[8*i +: 8];
      end
      else
      begin
        part1.be[s-4]              = 1'b1;
        part1.wdata[8*(s-4) +: 8] = req.wdata[8*i +: 8];
      end
      err = err | in_err_range(b);
      if (req.we)
        model[b] = req.wdata[8*i +: 8];
      else
        val[8*i +: 8] = model[b];
    end
    if (!req.we && req.sign_ext && (n == 1))
      val = {{24{val[7]}}, val[7:0]};
    if (!req.we && req.sign_ext && (n == 2))
      val = {{16{val[15]}}, val[15:0]};
    exp_bus.push_back(part0);
    if (part1.be != '0)
      exp_bus.push_back(part1);
    exp_rsp.push_back({val, err, req.we});
    last_addr = a;
  endtask

  // Granted transaction against the next expected part
  task automatic check_bus_part();
    lsu_pkg::bus_req_t exp;
    if (exp_bus.size() == 0)
    begin
      $display("Bus transaction granted at %0t with none expected", $time);
      bus_errs++;
    end
    else
    begin
      exp = exp_bus.pop_front();
      if (bus_req_data.addr[1:0] != 2'b00)
      begin
        $display("CHECK FAILED @%0t: bus address 0x%08h not word aligned", $time,
                 bus_req_data.addr);
        bus_errs++;
      end
      if ((bus_req_data.addr !== exp.addr) || (bus_req_data.be !== exp.be) ||
          (bus_req_data.we !== exp.we))
      begin
        $display("CHECK FAILED @%0t: bus addr 0x%08h be %b we %b, expected 0x%08h %b %b",
                 $time, bus_req_data.addr, bus_req_data.be, bus_req_data.we,
                 exp.addr, exp.be, exp.we);
        bus_errs++;
      end
      for (int l = 0; l < 4; l++)
      begin
        if (exp.we && exp.be[l] && (bus_req_data.wdata[8*l +: 8] !== exp.wdata[8*l +: 8]))
        begin
          $display("CHECK FAILED @%0t: write lane %0d is 0x%02h, expected 0x%02h", $time, l,
                   bus_req_data.wdata[8*l +: 8], exp.wdata[8*l +: 8]);
          bus_errs++;
        end
      end
    end
  endtask

  // Memory side of a grant that reads now and answers later in order
  task automatic accept_txn();
    logic [5:0] w;
    pend_t      p;
    int         d;
    w           = bus_req_data.addr[7:2];
    p.rsp.rdata = {mem[{w, 2'd3}], mem[{w, 2'd2}], mem[{w, 2'd1}], mem[{w, 2'd0}]};
    p.rsp.err   = in_err_range({w, 2'b00});
    for (int l = 0; l < 4; l++)
    begin
      if (bus_req_data.we && bus_req_data.be[l])
        mem[{w, l[1:0]}] = bus_req_data.wdata[8*l +: 8];
    end
    d        = 1 + int'(rand_bits(2) % 3);
    last_due = (resp_cycle + d - 1 > last_due) ? (resp_cycle + d - 1) : last_due;
    p.due    = last_due;
    pend.push_back(p);
  endtask

  ////////////////////////////////////////////////////////////
  // Bus memory
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      bus_gnt    <= 1'b0;
      bus_rvalid <= 1'b0;
      bus_rsp    <= '0;
    end
    else
    begin
      resp_cycle++;
      // Busy while anything is in flight or requested
      if (busy !== ((outstanding != 0) || bus_req))
      begin
        $display("CHECK FAILED @%0t: busy %b with %0d outstanding and request %b", $time,
                 busy, outstanding, bus_req);
        bus_errs++;
      end
      if (bus_req && bus_gnt)
      begin
        // Two in flight means the LSU must wait
        if (outstanding >= 2)
        begin
          $display("CHECK FAILED @%0t: grant with %0d transactions outstanding", $time,
                   outstanding);
          bus_errs++;
        end
        check_bus_part();
        accept_txn();
      end
      outstanding = outstanding + ((bus_req && bus_gnt) ? 1 : 0) - (bus_rvalid ? 1 : 0);
      bus_gnt <= (rand_bits(2) != 0);
      if ((pend.size() != 0) && (resp_cycle >= pend[0].due))
      begin
        bus_rvalid <= 1'b1;
        bus_rsp    <= pend[0].rsp;
        pend.pop_front();
      end
      else
      begin
        bus_rvalid <= 1'b0;
        bus_rsp    <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Core response check and run limit
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n && core_rsp_valid)
    begin
      if (exp_rsp.size() == 0)
      begin
        $display("Core response at %0t with no access waiting for one", $time);
        misc_errs++;
      end
      else
      begin
        got = exp_rsp.pop_front();
        rsp_count++;
        // Store data is undefined
        if (!got.we && (core_rsp_rdata !== got.data))
        begin
          $display("CHECK FAILED @%0t: load data 0x%08h, expected 0x%08h", $time,
                   core_rsp_rdata, got.data);
          data_errs++;
        end
        if (core_rsp_err !== got.err)
        begin
          $display("CHECK FAILED @%0t: error flag %b, expected %b", $time, core_rsp_err,
                   got.err);
          flag_errs++;
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    lfsr           = 32'haf65;
    clk            = 1'b0;
    rst_n          = 1'b0;
    core_req_valid = 1'b0;
    core_req       = '0;
    bus_gnt        = 1'b0;
    bus_rvalid     = 1'b0;
    bus_rsp        = '0;
    last_addr      = '0;
    cycles         = 0;
    resp_cycle     = 0;
    last_due       = 0;
    outstanding    = 0;
    rsp_count      = 0;
    data_errs      = 0;
    flag_errs      = 0;
    bus_errs       = 0;
    misc_errs      = 0;
    for (int i = 0; i < 256; i++)
    begin
      mem[i]   = (i[7:0] * 8'd37) ^ 8'h5C;
      model[i] = mem[i];
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (busy || bus_req || core_rsp_valid || core_req_ready)
    begin
      $display("Outputs not idle after reset at %0t", $time);
      misc_errs++;
    end
    for (int k = 0; k < N_ACC; k++)
    begin
      // Occasional idle cycle between accesses
      if (rand_bits(3) == 0)
      begin
        core_req_valid <= 1'b0;
        @(posedge clk);
      end
      make_access(next_req);
      core_req_valid <= 1'b1;
      core_req       <= next_req;
      @(posedge clk);
      while (!core_req_ready)
        @(posedge clk);
    end
    core_req_valid <= 1'b0;
    while (exp_rsp.size() != 0)
      @(posedge clk);
    repeat (3) @(posedge clk);
    if (busy || bus_req || core_rsp_valid)
    begin
      $display("Outputs not idle after the last response at %0t", $time);
      misc_errs++;
    end
    if ((exp_bus.size() != 0) || (rsp_count != N_ACC))
    begin
      $display("Run ended with %0d bus parts missing and %0d of %0d responses",
               exp_bus.size(), rsp_count, N_ACC);
      misc_errs++;
    end
    for (int i = 0; i < 256; i++)
    begin
      if (mem[i] !== model[i])
      begin
        $display("CHECK FAILED @%0t: memory byte 0x%02h is 0x%02h, expected 0x%02h", $time,
                 i, mem[i], model[i]);
        data_errs++;
      end
    end
    $display("Errors: data %0d, error flag %0d, bus %0d, other %0d over %0d responses",
             data_errs, flag_errs, bus_errs, misc_errs, rsp_count);
    if ((data_errs + flag_errs + bus_errs + misc_errs) == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
